/* hw/cpu_macros.svh */
// cpu global constants
// word width, register count, reset pc and the halt opcode
// shared by the types package and the sequential blocks
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and address width
`define CPU_WORD_W 32

// architectural registers, r0 included
`define CPU_REG_CNT 32

// first fetch address after reset
`define CPU_PC_INIT 32'h0000_0000

// opcode that stops the core
`define CPU_HALT_OP 6'h3f

`endif

/* hw/cpu_types_pkg.sv */
// cpu types package
// word and field types, decoded opcode and funct codes,
// alu operations and the datapath mux selects
`include "cpu_macros.svh"

package cpu_types_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [4:0] regbits_t;
  typedef logic [15:0] imm16_t;

  // opcodes the core understands
  typedef enum logic [5:0] {
    op_rtype = 6'h00,
    op_j     = 6'h02,
    op_jal   = 6'h03,
    op_beq   = 6'h04,
    op_bne   = 6'h05,
    op_addi  = 6'h08,
    op_addiu = 6'h09,
    op_slti  = 6'h0a,
    op_sltiu = 6'h0b,
    op_andi  = 6'h0c,
    op_ori   = 6'h0d,
    op_xori  = 6'h0e,
    op_lui   = 6'h0f,
    op_lw    = 6'h23,
    op_sw    = 6'h2b,
    op_halt  = `CPU_HALT_OP
  } opcode_t;

  // r-type function field
  typedef enum logic [5:0] {
    fn_sll  = 6'h00,
    fn_srl  = 6'h02,
    fn_jr   = 6'h08,
    fn_add  = 6'h20,
    fn_addu = 6'h21,
    fn_sub  = 6'h22,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_xor  = 6'h26,
    fn_nor  = 6'h27,
    fn_slt  = 6'h2a,
    fn_sltu = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    alu_sll, alu_srl, alu_add, alu_sub, alu_and,
    alu_or, alu_xor, alu_nor, alu_slt, alu_sltu
  } aluop_t;

  // alu port b source
  typedef enum logic {src_reg, src_imm} alu_src_t;

  // register write destination, ra for jal
  typedef enum logic [1:0] {dest_rd, dest_rt, dest_ra} reg_dest_t;

  // write-back source
  typedef enum logic [1:0] {wb_result, wb_npc, wb_dload, wb_lui} wb_sel_t;

  // next pc source
  typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump, pc_jr} pc_src_t;

endpackage

/* hw/cpu_ifs.sv */
// internal cpu interfaces
// control_unit_if carries the instruction in and the decode out,
// register_file_if carries the two read ports and the write port
`timescale 1ns/1ps

interface control_unit_if import cpu_types_pkg::*; ();
  // inputs to decode
  word_t instruction;
  logic equal;

  // instruction fields
  regbits_t rs, rt, rd;
  imm16_t imm16;
  logic [25:0] jump_addr;

  // datapath controls
  aluop_t alu_op;
  alu_src_t alu_src;
  reg_dest_t reg_dest;
  wb_sel_t wb_sel;
  pc_src_t pc_src;
  logic extend;
  logic reg_wen;

  // memory and halt requests
  logic i_ren, d_ren, d_wen, halt;

  modport control_unit (
    input instruction, equal,
    output rs, rt, rd, imm16, jump_addr,
    output alu_op, alu_src, reg_dest, wb_sel, pc_src, extend, reg_wen,
    output i_ren, d_ren, d_wen, halt
  );

  modport datapath (
    output instruction, equal,
    input rs, rt, rd, imm16, jump_addr,
    input alu_op, alu_src, reg_dest, wb_sel, pc_src, extend, reg_wen,
    input i_ren, d_ren, d_wen, halt
  );
endinterface

interface register_file_if import cpu_types_pkg::*; ();
  logic wen;
  regbits_t wsel, rsel1, rsel2;
  word_t wdat, rdat1, rdat2;

  modport register_file (input wen, wsel, wdat, rsel1, rsel2, output rdat1, rdat2);
  modport datapath (output wen, wsel, wdat, rsel1, rsel2, input rdat1, rdat2);
endinterface

/* hw/alu.sv */
// alu
// combinational arithmetic, logic, compare and shift unit
// shifts move b by the amount in a[4:0]; zero flags an all-zero result
`timescale 1ns/1ps

module alu import cpu_types_pkg::*; (
  input  word_t  a,
  input  word_t  b,
  input  aluop_t op,
  output word_t  result,
  output logic   zero
);

  always_comb begin
    // unlisted encodings give zero
    result = '0;
    case (op)
      alu_sll:  result = b << a[4:0];
      alu_srl:  result = b >> a[4:0];
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_and:  result = a & b;
      alu_or:   result = a | b;
      alu_xor:  result = a ^ b;
      alu_nor:  result = ~(a | b);
      // signed compare for slt, slti
      alu_slt:  result = word_t'($signed(a) < $signed(b));
      alu_sltu: result = word_t'(a < b);
      default:  result = '0;
    endcase
  end

  // beq/bne look at this
  assign zero = (result == '0);

  // known operands mean a decoded instruction, so the op must be known too
  always_comb begin
    if (!$isunknown({a, b})) begin
      assert (!$isunknown(op))
        else $error("alu: op unknown while operands are valid");
    end
  end

endmodule

/* hw/register_file.sv */
// register file
// 32 words, r0 reads zero and drops writes
// two asynchronous reads, one write on the rising edge
`timescale 1ns/1ps
`include "cpu_macros.svh"

module register_file import cpu_types_pkg::*; (
  input logic CLK,
  input logic arst_n,
  register_file_if.register_file rf
);

  // r0 has no storage
  word_t regs [1:`CPU_REG_CNT-1];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < `CPU_REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.wen && (rf.wsel != '0)) begin
      regs[rf.wsel] <= rf.wdat;
    end
  end

  // read ports, r0 forced to zero
  assign rf.rdat1 = (rf.rsel1 == '0) ? '0 : regs[rf.rsel1];
  assign rf.rdat2 = (rf.rsel2 == '0) ? '0 : regs[rf.rsel2];

  // write select comes from decode through the dest mux
  a_wsel_known: assert property (
    @(posedge CLK) disable iff (!arst_n)
    rf.wen |-> !$isunknown(rf.wsel)
  ) else $error("register_file: write with unknown wsel");

endmodule

/* hw/control_unit.sv */
// control unit
// slices the instruction into fields and decodes opcode and funct
// into mux selects, alu op, enables and the next pc source
`timescale 1ns/1ps

module control_unit import cpu_types_pkg::*; (
  control_unit_if.control_unit cu
);

  opcode_t opcode;
  funct_t funct;
  pc_src_t pc_src_dec;
  logic is_beq, is_bne;

  assign opcode = opcode_t'(cu.instruction[31:26]);
  assign funct  = funct_t'(cu.instruction[5:0]);

  // field slicing
  assign cu.rs        = cu.instruction[25:21];
  assign cu.rt        = cu.instruction[20:16];
  assign cu.rd        = cu.instruction[15:11];
  assign cu.imm16     = cu.instruction[15:0];
  assign cu.jump_addr = cu.instruction[25:0];

  // fetch is always wanted, halt is applied in the request unit
  assign cu.i_ren = 1'b1;

  always_comb begin
    // defaults decode as a no-op
    cu.alu_op   = alu_add;
    cu.alu_src  = src_reg;
    cu.reg_dest = dest_rd;
    cu.wb_sel   = wb_result;
    cu.extend   = 1'b1;
    cu.reg_wen  = 1'b0;
    cu.d_ren    = 1'b0;
    cu.d_wen    = 1'b0;
    cu.halt     = 1'b0;
    pc_src_dec  = pc_seq;
    is_beq      = 1'b0;
    is_bne      = 1'b0;

    case (opcode)
      op_rtype: begin
        cu.reg_wen = 1'b1;
        case (funct)
          fn_sll:          cu.alu_op = alu_sll;
          fn_srl:          cu.alu_op = alu_srl;
          fn_add, fn_addu: cu.alu_op = alu_add;
          fn_sub, fn_subu: cu.alu_op = alu_sub;
          fn_and:          cu.alu_op = alu_and;
          fn_or:           cu.alu_op = alu_or;
          fn_xor:          cu.alu_op = alu_xor;
          fn_nor:          cu.alu_op = alu_nor;
          fn_slt:          cu.alu_op = alu_slt;
          fn_sltu:         cu.alu_op = alu_sltu;
          fn_jr: begin
            cu.reg_wen = 1'b0;
            pc_src_dec = pc_jr;
          end
          // unknown funct, nothing written
          default:         cu.reg_wen = 1'b0;
        endcase
      end
      op_addi, op_addiu, op_slti, op_sltiu,
      op_andi, op_ori, op_xori: begin
        cu.alu_src  = src_imm;
        cu.reg_dest = dest_rt;
        cu.reg_wen  = 1'b1;
        case (opcode)
          op_slti:  cu.alu_op = alu_slt;
          op_sltiu: cu.alu_op = alu_sltu;
          op_andi:  cu.alu_op = alu_and;
          op_ori:   cu.alu_op = alu_or;
          op_xori:  cu.alu_op = alu_xor;
          default:  cu.alu_op = alu_add;
        endcase
        // logical immediates zero-extend
        cu.extend = !(opcode inside {op_andi, op_ori, op_xori});
      end
      op_lui: begin
        cu.reg_dest = dest_rt;
        cu.wb_sel   = wb_lui;
        cu.reg_wen  = 1'b1;
      end
      op_lw: begin
        cu.alu_src  = src_imm;
        cu.reg_dest = dest_rt;
        cu.wb_sel   = wb_dload;
        cu.reg_wen  = 1'b1;
        cu.d_ren    = 1'b1;
      end
      op_sw: begin
        // address = rs + imm, data = rt
        cu.alu_src = src_imm;
        cu.d_wen   = 1'b1;
      end
      op_beq, op_bne: begin
        // subtract, equal comes back as alu zero
        cu.alu_op = alu_sub;
        is_beq    = (opcode == op_beq);
        is_bne    = (opcode == op_bne);
      end
      op_j: pc_src_dec = pc_jump;
      op_jal: begin
        pc_src_dec  = pc_jump;
        cu.reg_dest = dest_ra;
        cu.wb_sel   = wb_npc;
        cu.reg_wen  = 1'b1;
      end
      op_halt: cu.halt = 1'b1;
      default: ;
    endcase
  end

  // branch resolution kept apart from decode, equal depends on alu_op
  assign cu.pc_src = ((is_beq && cu.equal) || (is_bne && !cu.equal)) ? pc_branch
                                                                     : pc_src_dec;

endmodule

/* hw/program_counter.sv */
// program counter
// pc register and next-pc selection, updates only on retire
`timescale 1ns/1ps
`include "cpu_macros.svh"

module program_counter import cpu_types_pkg::*; (
  input  logic        CLK,
  input  logic        arst_n,
  input  logic        retire,
  input  pc_src_t     pc_src,
  input  imm16_t      imm16,
  input  logic [25:0] jump_addr,
  input  word_t       jr_addr,
  output word_t       pc,
  output word_t       npc
);

  word_t pc_next;

  assign npc = pc + word_t'(4);

  always_comb begin
    case (pc_src)
      // npc + sign-extended word offset
      pc_branch: pc_next = npc + {{14{imm16[15]}}, imm16, 2'b00};
      // region of npc, word address from the instruction
      pc_jump:   pc_next = {npc[31:28], jump_addr, 2'b00};
      pc_jr:     pc_next = jr_addr;
      default:   pc_next = npc;
    endcase
  end

  // holds while fetch or data access is pending
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) pc <= `CPU_PC_INIT;
    else if (retire) pc <= pc_next;
  end

  // jr takes a register value, so alignment is not guaranteed by decode
  a_pc_aligned: assert property (
    @(posedge CLK) disable iff (!arst_n) pc[1:0] == 2'b00
  ) else $error("program_counter: pc not word aligned");

endmodule

/* hw/request_unit.sv */
// request unit
// drives the data strobes for the current instruction until dhit,
// decides when an instruction retires and latches halt
`timescale 1ns/1ps

module request_unit (
  input  logic CLK,
  input  logic arst_n,
  input  logic ihit,
  input  logic dhit,
  input  logic d_ren,
  input  logic d_wen,
  input  logic halt_dec,
  output logic dmem_ren,
  output logic dmem_wen,
  output logic retire,
  output logic halted
);

  logic done;
  logic d_req;

  // data access needed by the decoded instruction
  assign d_req = d_ren || d_wen;

  // strobes drop once the access is served
  assign dmem_ren = d_ren && !done && !halted;
  assign dmem_wen = d_wen && !done && !halted;

  // fetch valid and data side finished
  assign retire = ihit && !halted && (!d_req || done || dhit);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      done   <= 1'b0;
      halted <= 1'b0;
    end else begin
      // new instruction, new request
      if (retire) done <= 1'b0;
      else if (dhit && (dmem_ren || dmem_wen)) done <= 1'b1;
      // sticky until reset
      if (retire && halt_dec) halted <= 1'b1;
    end
  end

  a_rw_exclusive: assert property (
    @(posedge CLK) disable iff (!arst_n) !(dmem_ren && dmem_wen)
  ) else $error("request_unit: read and write strobes together");

  // an open request waits for its hit
  a_req_held: assert property (
    @(posedge CLK) disable iff (!arst_n)
    (dmem_ren || dmem_wen) && !dhit && !retire |=> (dmem_ren || dmem_wen)
  ) else $error("request_unit: request dropped before dhit");

endmodule

/* hw/datapath.sv */
// datapath, top level of the single-cycle core
// wires control, register file, alu, pc and request unit together
// and holds the extender and the alu-src, dest and write-back muxes
`timescale 1ns/1ps

module datapath import cpu_types_pkg::*; (
  input  logic  CLK,
  input  logic  arst_n,
  // instruction port
  input  word_t imem_load,
  output word_t imem_addr,
  output logic  imem_ren,
  input  logic  ihit,
  // data port
  input  word_t dmem_load,
  output word_t dmem_store,
  output word_t dmem_addr,
  output logic  dmem_ren,
  output logic  dmem_wen,
  input  logic  dhit,
  output logic  halt
);

  control_unit_if cuif();
  register_file_if rfif();

  word_t imm16_ext, port_a, port_b, wdat;
  word_t alu_result, pc, npc;
  regbits_t wsel;
  logic alu_zero;
  logic retire;

  control_unit cu0 (.cu(cuif.control_unit));

  register_file rf0 (
    .CLK    (CLK),
    .arst_n (arst_n),
    .rf     (rfif.register_file)
  );

  alu alu0 (
    .a      (port_a),
    .b      (port_b),
    .op     (cuif.alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  program_counter pc0 (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .retire    (retire),
    .pc_src    (cuif.pc_src),
    .imm16     (cuif.imm16),
    .jump_addr (cuif.jump_addr),
    .jr_addr   (rfif.rdat1),
    .pc        (pc),
    .npc       (npc)
  );

  request_unit ru0 (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .ihit     (ihit),
    .dhit     (dhit),
    .d_ren    (cuif.d_ren),
    .d_wen    (cuif.d_wen),
    .halt_dec (cuif.halt),
    .dmem_ren (dmem_ren),
    .dmem_wen (dmem_wen),
    .retire   (retire),
    .halted   (halt)
  );

  // control inputs
  assign cuif.instruction = imem_load;
  assign cuif.equal       = alu_zero;

  // register file hookup, writes only land at retire
  assign rfif.rsel1 = cuif.rs;
  assign rfif.rsel2 = cuif.rt;
  assign rfif.wsel  = wsel;
  assign rfif.wdat  = wdat;
  assign rfif.wen   = cuif.reg_wen && retire;

  // memory side
  assign imem_addr  = pc;
  assign imem_ren   = cuif.i_ren && !halt;
  assign dmem_addr  = alu_result;
  assign dmem_store = rfif.rdat2;

  // immediate extender
  assign imm16_ext = cuif.extend ? {{16{cuif.imm16[15]}}, cuif.imm16}
                                 : {16'h0000, cuif.imm16};

  // shifts take shamt, which sits in imm16[10:6]
  assign port_a = (cuif.alu_op inside {alu_sll, alu_srl}) ? word_t'(cuif.imm16[10:6])
                                                          : rfif.rdat1;

  // alu port b
  assign port_b = (cuif.alu_src == src_imm) ? imm16_ext : rfif.rdat2;

  // write select
  always_comb begin
    case (cuif.reg_dest)
      dest_rt: wsel = cuif.rt;
      dest_ra: wsel = 5'd31;
      default: wsel = cuif.rd;
    endcase
  end

  // write-back source
  always_comb begin
    case (cuif.wb_sel)
      wb_npc:   wdat = npc;
      wb_dload: wdat = dmem_load;
      // lui, immediate in the upper half
      wb_lui:   wdat = {cuif.imm16, 16'h0000};
      default:  wdat = alu_result;
    endcase
  end

endmodule

/* dv/datapath_tb.sv */
// testbench for the single-cycle core
// instruction and data memory models with random hit latency,
// store sequence checked against the data file, plus halt and reset
`timescale 1ns/1ps
`include "cpu_macros.svh"

module datapath_tb import cpu_types_pkg::*; ();

  localparam int MEM_WORDS    = 1024;
  localparam int RETIRE_LIMIT = 40;
  localparam int RUN_LIMIT    = 3000;

  logic  CLK = 1'b0;
  logic  arst_n;
  word_t imem_load, imem_addr, dmem_load, dmem_store, dmem_addr;
  logic  imem_ren, ihit, dmem_ren, dmem_wen, dhit, halt;

  // memories, indexed by word
  word_t imem [MEM_WORDS];
  word_t dmem [MEM_WORDS];
  // expected stores, in program order
  word_t exp_addr [$];
  word_t exp_data [$];

  integer seed = 54127;
  int     errors, checks, n_exp, n_stores, hr_errors;
  int     grp_errors, grp_checks, cur_grp;
  int     icnt, dcnt, idle, cycles;
  logic   d_active, next_dhit, retire, prev_open, prev_hit, aborted;
  word_t  prev_addr, prev_store;

  datapath dut0 (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .imem_load  (imem_load),
    .imem_addr  (imem_addr),
    .imem_ren   (imem_ren),
    .ihit       (ihit),
    .dmem_load  (dmem_load),
    .dmem_store (dmem_store),
    .dmem_addr  (dmem_addr),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .dhit       (dhit),
    .halt       (halt)
  );

  // 4 ns period
  always #2 CLK = ~CLK;

  // store groups by address, 0x1xx .. 0x4xx
  function automatic string test_name(int grp);
    case (grp)
      1:       test_name = "rtype_shift";
      2:       test_name = "immediates";
      3:       test_name = "load_store";
      4:       test_name = "control_flow";
      default: test_name = "halt_reset";
    endcase
  endfunction

  // P lines fill both memories, E lines queue expected stores
  task automatic load_program();
    int fd;
    int n;
    string line;
    logic [7:0] tag;
    word_t a, d;
    fd = $fopen("dv/program_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open the program file dv/program_input.txt");
      aborted = 1'b1;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        n = $sscanf(line, "%c %h %h", tag, a, d);
        if (n == 3 && tag == "P") begin
          imem[a[11:2]] = d;
          dmem[a[11:2]] = d;
        end else if (n == 3 && tag == "E") begin
          exp_addr.push_back(a);
          exp_data.push_back(d);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic report_group();
    string verdict;
    if (cur_grp != 0) begin
      if (grp_errors == 0) verdict = "ok";
      else verdict = "failed";
      $display("test %s: %0d checks, %0d errors, %s", test_name(cur_grp), grp_checks,
               grp_errors, verdict);
    end
  endtask

  // one completed write, compared with the head of the queue
  task automatic check_store();
    word_t ea, ed;
    int grp;
    n_stores++;
    if (exp_addr.size() == 0) begin
      $display("unexpected store of %h to %h after the last expected store",
               dmem_store, dmem_addr);
      hr_errors++;
    end else begin
      ea = exp_addr.pop_front();
      ed = exp_data.pop_front();
      grp = int'(ea[11:8]);
      // first store of the next test closes the previous one
      if (grp != cur_grp) begin
        report_group();
        cur_grp = grp;
        grp_checks = 0;
        grp_errors = 0;
      end
      checks++;
      grp_checks++;
      if (dmem_addr != ea || dmem_store != ed) begin
        $display("[ERROR] %s: expected %h at %h, actual %h at %h", test_name(grp), ed, ea,
                 dmem_store, dmem_addr);
        errors++;
        grp_errors++;
      end
    end
  endtask

  // falling edge, outputs are settled here
  task automatic sample_cycle();
    logic req_open;
    req_open = dmem_ren || dmem_wen;
    // retire rule, fetch valid and no open data request
    retire = ihit && !halt && (!req_open || dhit);
    if (dmem_ren && dmem_wen) begin
      $display("read and write strobes are high in the same cycle");
      errors++;
      grp_errors++;
    end
    // a request without its hit must stay, with the same address and data
    if (prev_open && !prev_hit) begin
      if (!req_open || dmem_addr != prev_addr || (dmem_wen && dmem_store != prev_store)) begin
        $display("data request dropped or changed before its dhit at %h", prev_addr);
        errors++;
        grp_errors++;
      end
    end
    if (dmem_wen && dhit) begin
      check_store();
      dmem[dmem_addr[11:2]] = dmem_store;
    end
    // data latency counted from the first cycle the request is seen
    if (req_open && !dhit) begin
      if (!d_active) begin
        d_active = 1'b1;
        dcnt = $random(seed) & 3;
      end else if (dcnt > 0) begin
        dcnt--;
      end
      next_dhit = (dcnt == 0);
    end else begin
      d_active = 1'b0;
      next_dhit = 1'b0;
    end
    // new fetch latency after each retire
    if (retire) begin
      icnt = $random(seed) & 3;
      idle = 0;
    end else begin
      if (icnt > 0) icnt--;
      idle++;
    end
    prev_open  = req_open;
    prev_hit   = dhit;
    prev_addr  = dmem_addr;
    prev_store = dmem_store;
  endtask

  // 1 ns after the rising edge
  task automatic drive_inputs();
    imem_load = imem[imem_addr[11:2]];
    ihit      = imem_ren && (icnt == 0);
    dhit      = next_dhit;
    // the address held since the last sample
    dmem_load = dmem[prev_addr[11:2]];
  endtask

  initial begin
    arst_n = 1'b0;
    ihit = 1'b0;
    dhit = 1'b0;
    imem_load = '0;
    dmem_load = '0;
    errors = 0;
    checks = 0;
    n_stores = 0;
    hr_errors = 0;
    grp_errors = 0;
    grp_checks = 0;
    cur_grp = 0;
    icnt = 0;
    dcnt = 0;
    idle = 0;
    cycles = 0;
    d_active = 1'b0;
    next_dhit = 1'b0;
    prev_open = 1'b0;
    prev_hit = 1'b0;
    prev_addr = '0;
    prev_store = '0;
    aborted = 1'b0;
    // data fill tracks the byte address of each word
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = '0;
      dmem[i] = 32'hd000_0000 | word_t'(i << 2);
    end
    load_program();
    n_exp = exp_addr.size();

    repeat (8) @(posedge CLK);
    #1;
    // state while reset is still held
    checks += 2;
    if (imem_addr != `CPU_PC_INIT) begin
      $display("[ERROR] halt_reset: reset pc expected %h, actual %h", `CPU_PC_INIT, imem_addr);
      hr_errors++;
    end
    if (dmem_ren || dmem_wen || halt) begin
      $display("[ERROR] halt_reset: ren wen halt expected 000, actual %b%b%b",
               dmem_ren, dmem_wen, halt);
      hr_errors++;
    end
    arst_n = 1'b1;
    icnt = $random(seed) & 3;
    drive_inputs();

    while (!halt && !aborted) begin
      @(negedge CLK);
      sample_cycle();
      cycles++;
      if (idle > RETIRE_LIMIT) begin
        $display("timeout, no instruction retired for %0d cycles", RETIRE_LIMIT);
        aborted = 1'b1;
      end else if (cycles > RUN_LIMIT) begin
        $display("timeout, halt not reached within %0d cycles", RUN_LIMIT);
        aborted = 1'b1;
      end else begin
        @(posedge CLK);
        #1;
        drive_inputs();
      end
    end

    // halted core stays quiet
    for (int k = 0; k < 10 && !aborted; k++) begin
      @(negedge CLK);
      if (dmem_ren || dmem_wen || imem_ren || !halt) begin
        $display("memory activity or halt drop after halt, cycle %0d", k);
        hr_errors++;
      end
      @(posedge CLK);
      #1;
      drive_inputs();
    end
    checks++;
    if (n_stores != n_exp) begin
      $display("[ERROR] halt_reset: store count expected %0d, actual %0d", n_exp, n_stores);
      hr_errors++;
    end
    report_group();
    $display("test halt_reset: %0d errors", hr_errors);
    errors += hr_errors;
    $display("checks: %0d, stores: %0d, errors: %0d", checks, n_stores, errors);
    if (errors == 0 && !aborted) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* dv/program_input.txt */
# P <byte address> <word>  program or initial data word, hex
# E <byte address> <data>  expected store in program order, hex
# setup: r1 = 0x1234, r2 = 0xf0f000ff
P 000 34011234
P 004 3c02f0f0
P 008 344200ff
# r-type and shifts, stored at 0x100
P 00c 00221821
P 010 ac030100
P 014 00222023
P 018 ac040104
P 01c 00222824
P 020 ac050108
P 024 00223025
P 028 ac06010c
P 02c 00223826
P 030 ac070110
P 034 00224027
P 038 ac080114
P 03c 0041482a
P 040 ac090118
P 044 0041502b
P 048 ac0a011c
P 04c 00015900
P 050 ac0b0120
P 054 00026202
P 058 ac0c0124
# andi ori xori addiu slti lui, stored at 0x200
P 05c 304d8f0f
P 060 ac0d0200
P 064 340e8000
P 068 ac0e0204
P 06c 384fffff
P 070 ac0f0208
P 074 2430fff0
P 078 ac10020c
P 07c 2831ff00
P 080 ac110210
P 084 3c128765
P 088 ac120214
# sw then lw to the same word, and lw of preloaded data
P 08c ac020300
P 090 8c130300
P 094 ac130304
P 098 8c140380
P 09c ac140308
# beq taken, bne not taken, j, jal and jr; poison stores at 0x4fx
P 0a0 10210001
P 0a4 ac0004f0
P 0a8 ac010400
P 0ac 14210001
P 0b0 ac020404
P 0b4 0800002f
P 0b8 ac0004f4
P 0bc 0c000034
P 0c0 ac1f0408
P 0c4 08000035
P 0d0 03e00008
P 0d4 fc000000
P 0d8 ac0104fc
P 380 cafef00d
E 100 f0f01333
E 104 0f101135
E 108 00000034
E 10c f0f012ff
E 110 f0f012cb
E 114 0f0fed00
E 118 00000001
E 11c 00000000
E 120 00012340
E 124 00f0f000
E 200 0000000f
E 204 00008000
E 208 f0f0ff00
E 20c 00001224
E 210 00000000
E 214 87650000
E 300 f0f000ff
E 304 f0f000ff
E 308 cafef00d
E 400 00001234
E 404 f0f000ff
E 408 000000c0

/* files.f */
+incdir+hw
hw/cpu_types_pkg.sv
hw/cpu_ifs.sv
hw/alu.sv
hw/register_file.sv
hw/control_unit.sv
hw/program_counter.sv
hw/request_unit.sv
hw/datapath.sv
dv/datapath_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the core testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module datapath_tb -f files.f \
    -o datapath_sim --Mdir obj_dir \
  && ./obj_dir/datapath_sim | tee /dev/stderr | grep -q "^Result: PASSED$" \
  && echo "simulation run ok" \
  || { echo "simulation run failed"; exit 1; }
